// File: source/tti_pkg.sv
//*************************************************
// Shared widths and interrupt source encoding for the
// target transaction interface glue
//*************************************************

package tti_pkg;

  // Interrupt sources handled by the TTI
  localparam int unsigned NumIrq = 6;

  // Descriptor word width on both queue ports
  localparam int unsigned DescDataWidth = 32;

  // Bit position of each source inside an interrupt vector
  typedef enum logic [$clog2(NumIrq)-1:0] {
    IRQ_RX_DESC          = 3'd0,
    IRQ_RX_DESC_THLD     = 3'd1,
    IRQ_RX_DATA_THLD     = 3'd2,
    IRQ_IBI_DONE         = 3'd3,
    IRQ_TX_DESC_COMPLETE = 3'd4,
    IRQ_TX_DESC_START    = 3'd5
  } irq_src_e;

  // One bit per source, indexed by irq_src_e
  typedef logic [NumIrq-1:0] irq_vec_t;

  // Single descriptor word
  typedef logic [DescDataWidth-1:0] desc_t;

endpackage : tti_pkg

// File: source/tti_event_if.sv
//*************************************************
// Registered interrupt event strobes, capture to status
//*************************************************

`timescale 1ns/1ps

interface tti_event_if;
  import tti_pkg::*;

  // Sources firing this cycle
  irq_vec_t set_vec;
  // Clears from queue reads and IBI status reads
  irq_vec_t hw_clr_vec;
  // Software write-one-to-clear
  irq_vec_t sw_clr_vec;
  // Software force
  irq_vec_t force_vec;

  modport capture (
    output set_vec,
    output hw_clr_vec,
    output sw_clr_vec,
    output force_vec
  );

  modport status (
    input set_vec,
    input hw_clr_vec,
    input sw_clr_vec,
    input force_vec
  );

endinterface : tti_event_if

// File: source/tti_event_capture.sv
//*************************************************
// First interrupt stage, maps raw strobes to per-source
// set and clear vectors and registers them
//*************************************************

`timescale 1ns/1ps

module tti_event_capture (
  input  logic               clk_i,
  input  logic               rst_ni,

  input  logic               rx_desc_write_i,
  input  logic               rx_data_write_i,
  input  logic               rx_desc_thld_trig_i,
  input  logic               rx_data_thld_trig_i,
  input  logic               ibi_status_we_i,
  input  logic               tx_pr_start_i,
  input  logic               tx_pr_end_i,
  input  logic               recovery_mode_i,
  input  logic               rx_desc_queue_ack_i,
  input  logic               rx_data_queue_ack_i,
  input  logic               ibi_status_rd_i,

  input  tti_pkg::irq_vec_t  intr_w1c_i,
  input  tti_pkg::irq_vec_t  intr_force_i,

  tti_event_if.capture       ev
);
  import tti_pkg::*;

  irq_vec_t set_d;
  irq_vec_t hw_clr_d;

  // Recovery mode only lets the IBI source through
  always_comb begin
    set_d                       = '0;
    set_d[IRQ_RX_DESC]          = rx_desc_write_i & ~recovery_mode_i;
    set_d[IRQ_RX_DESC_THLD]     = rx_desc_write_i & rx_desc_thld_trig_i & ~recovery_mode_i;
    set_d[IRQ_RX_DATA_THLD]     = rx_data_write_i & rx_data_thld_trig_i & ~recovery_mode_i;
    set_d[IRQ_IBI_DONE]         = ibi_status_we_i;
    set_d[IRQ_TX_DESC_COMPLETE] = tx_pr_end_i & ~recovery_mode_i;
    set_d[IRQ_TX_DESC_START]    = tx_pr_start_i & ~recovery_mode_i;
  end

  // Private-read sources are cleared by W1C only
  always_comb begin
    hw_clr_d                   = '0;
    hw_clr_d[IRQ_RX_DESC]      = rx_desc_queue_ack_i;
    hw_clr_d[IRQ_RX_DESC_THLD] = rx_desc_queue_ack_i;
    hw_clr_d[IRQ_RX_DATA_THLD] = rx_data_queue_ack_i;
    hw_clr_d[IRQ_IBI_DONE]     = ibi_status_rd_i;
  end

  // All four vectors move together, lined up with the queue threshold update
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ev.set_vec    <= '0;
      ev.hw_clr_vec <= '0;
      ev.sw_clr_vec <= '0;
      ev.force_vec  <= '0;
    end else begin
      ev.set_vec    <= set_d;
      ev.hw_clr_vec <= hw_clr_d;
      ev.sw_clr_vec <= intr_w1c_i;
      ev.force_vec  <= intr_force_i;
    end
  end

  // Nothing but IBI done may fire for a cycle sampled in recovery mode
  a_recovery_gate : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $past(recovery_mode_i) |->
      ((ev.set_vec & ~(irq_vec_t'(1) << IRQ_IBI_DONE)) == '0)
  ) else $error("Recovery-gated interrupt source fired during recovery mode");

endmodule : tti_event_capture

// File: source/tti_irq_status.sv
//*************************************************
// Second interrupt stage, status flops and the single
// enabled interrupt line
//*************************************************

`timescale 1ns/1ps

module tti_irq_status (
  input  logic               clk_i,
  input  logic               rst_ni,

  tti_event_if.status        ev,

  input  tti_pkg::irq_vec_t  intr_enable_i,
  output tti_pkg::irq_vec_t  intr_status_o,
  output logic               irq_o
);
  import tti_pkg::*;

  irq_vec_t status_q;
  irq_vec_t status_d;
  irq_vec_t clr_vec;
  irq_vec_t set_any;

  assign clr_vec = ev.hw_clr_vec | ev.sw_clr_vec;
  assign set_any = ev.set_vec | ev.force_vec;

  // Set and force win over any clear in the same cycle
  always_comb begin
    status_d = status_q;
    for (int i = 0; i < NumIrq; i++) begin
      if (set_any[i]) begin
        status_d[i] = 1'b1;
      end else if (clr_vec[i]) begin
        status_d[i] = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      status_q <= '0;
    end else begin
      status_q <= status_d;
    end
  end

  assign intr_status_o = status_q;

  // Enable masks the line only, status stays visible
  assign irq_o = |(status_q & intr_enable_i);

  // Every captured set shows up in status one edge later
  a_set_reaches_status : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (ev.set_vec != '0) |=>
      ((intr_status_o & $past(ev.set_vec)) == $past(ev.set_vec))
  ) else $error("Interrupt set strobe did not reach the status bits");

  a_irq_masked : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ((intr_status_o & intr_enable_i) == '0) |-> !irq_o
  ) else $error("Interrupt raised with no enabled status bit");

endmodule : tti_irq_status

// File: source/tti_desc_port.sv
//*************************************************
// Register-side guard for the RX and TX descriptor queues
//*************************************************

`timescale 1ns/1ps

module tti_desc_port (
  // RX descriptor read side
  input  logic            csr_rx_desc_req_i,
  input  logic            rx_desc_queue_ack_i,
  input  logic            rx_desc_queue_empty_i,
  input  tti_pkg::desc_t  rx_desc_queue_data_i,
  output logic            csr_rx_desc_ack_o,
  output logic            rx_desc_queue_req_o,
  output tti_pkg::desc_t  csr_rx_desc_data_o,

  // TX descriptor write side
  input  logic            csr_tx_desc_req_i,
  input  logic            csr_tx_desc_is_wr_i,
  input  logic            tx_desc_queue_ack_i,
  input  logic            tx_desc_queue_full_i,
  input  tti_pkg::desc_t  csr_tx_desc_data_i,
  output logic            csr_tx_desc_ack_o,
  output logic            tx_desc_queue_req_o,
  output tti_pkg::desc_t  tx_desc_queue_data_o
);

  // Empty read is answered here with zero data
  always_comb begin
    if (csr_rx_desc_req_i && rx_desc_queue_empty_i) begin
      csr_rx_desc_ack_o   = csr_rx_desc_req_i;
      csr_rx_desc_data_o  = '0;
      rx_desc_queue_req_o = 1'b0;
    end else begin
      csr_rx_desc_ack_o   = rx_desc_queue_ack_i;
      csr_rx_desc_data_o  = rx_desc_queue_data_i;
      rx_desc_queue_req_o = csr_rx_desc_req_i;
    end
    if (!$isunknown({rx_desc_queue_empty_i, csr_rx_desc_req_i})) begin
      a_rx_no_empty_req : assert (!(rx_desc_queue_req_o && rx_desc_queue_empty_i))
        else $error("RX descriptor request issued to an empty queue");
    end
  end

  // Full write is acked and dropped
  always_comb begin
    if (csr_tx_desc_req_i && tx_desc_queue_full_i) begin
      csr_tx_desc_ack_o    = csr_tx_desc_req_i & csr_tx_desc_is_wr_i;
      tx_desc_queue_req_o  = 1'b0;
      tx_desc_queue_data_o = '0;
    end else begin
      csr_tx_desc_ack_o    = tx_desc_queue_ack_i;
      tx_desc_queue_req_o  = csr_tx_desc_req_i & csr_tx_desc_is_wr_i;
      tx_desc_queue_data_o = csr_tx_desc_data_i;
    end
    if (!$isunknown({tx_desc_queue_full_i, csr_tx_desc_req_i, csr_tx_desc_is_wr_i})) begin
      a_tx_no_full_req : assert (!(tx_desc_queue_req_o && tx_desc_queue_full_i))
        else $error("TX descriptor request issued to a full queue");
    end
  end

endmodule : tti_desc_port

// File: source/i3c_tti.sv
//*************************************************
// I3C target TTI glue top, interrupt pipeline plus the
// descriptor queue guard
//*************************************************

`timescale 1ns/1ps

module i3c_tti (
  input  logic               clk_i,
  input  logic               rst_ni,

  // Interrupt event inputs
  input  logic               rx_desc_write_i,
  input  logic               rx_data_write_i,
  input  logic               rx_desc_thld_trig_i,
  input  logic               rx_data_thld_trig_i,
  input  logic               ibi_status_we_i,
  input  logic               tx_pr_start_i,
  input  logic               tx_pr_end_i,
  input  logic               recovery_mode_i,
  input  logic               rx_desc_queue_ack_i,
  input  logic               rx_data_queue_ack_i,
  input  logic               ibi_status_rd_i,

  // Interrupt registers, software side
  input  tti_pkg::irq_vec_t  intr_w1c_i,
  input  tti_pkg::irq_vec_t  intr_force_i,
  input  tti_pkg::irq_vec_t  intr_enable_i,
  output tti_pkg::irq_vec_t  intr_status_o,
  output logic               irq_o,

  // RX descriptor queue
  input  logic               csr_rx_desc_req_i,
  input  logic               rx_desc_queue_empty_i,
  input  tti_pkg::desc_t     rx_desc_queue_data_i,
  output logic               csr_rx_desc_ack_o,
  output logic               rx_desc_queue_req_o,
  output tti_pkg::desc_t     csr_rx_desc_data_o,

  // TX descriptor queue
  input  logic               csr_tx_desc_req_i,
  input  logic               csr_tx_desc_is_wr_i,
  input  logic               tx_desc_queue_ack_i,
  input  logic               tx_desc_queue_full_i,
  input  tti_pkg::desc_t     csr_tx_desc_data_i,
  output logic               csr_tx_desc_ack_o,
  output logic               tx_desc_queue_req_o,
  output tti_pkg::desc_t     tx_desc_queue_data_o
);

  tti_event_if ev_if ();

  tti_event_capture u_capture (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .rx_desc_write_i     (rx_desc_write_i),
    .rx_data_write_i     (rx_data_write_i),
    .rx_desc_thld_trig_i (rx_desc_thld_trig_i),
    .rx_data_thld_trig_i (rx_data_thld_trig_i),
    .ibi_status_we_i     (ibi_status_we_i),
    .tx_pr_start_i       (tx_pr_start_i),
    .tx_pr_end_i         (tx_pr_end_i),
    .recovery_mode_i     (recovery_mode_i),
    .rx_desc_queue_ack_i (rx_desc_queue_ack_i),
    .rx_data_queue_ack_i (rx_data_queue_ack_i),
    .ibi_status_rd_i     (ibi_status_rd_i),
    .intr_w1c_i          (intr_w1c_i),
    .intr_force_i        (intr_force_i),
    .ev                  (ev_if.capture)
  );

  tti_irq_status u_status (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ev            (ev_if.status),
    .intr_enable_i (intr_enable_i),
    .intr_status_o (intr_status_o),
    .irq_o         (irq_o)
  );

  // RX ack also feeds the guard's pass-through path
  tti_desc_port u_desc_port (
    .csr_rx_desc_req_i     (csr_rx_desc_req_i),
    .rx_desc_queue_ack_i   (rx_desc_queue_ack_i),
    .rx_desc_queue_empty_i (rx_desc_queue_empty_i),
    .rx_desc_queue_data_i  (rx_desc_queue_data_i),
    .csr_rx_desc_ack_o     (csr_rx_desc_ack_o),
    .rx_desc_queue_req_o   (rx_desc_queue_req_o),
    .csr_rx_desc_data_o    (csr_rx_desc_data_o),
    .csr_tx_desc_req_i     (csr_tx_desc_req_i),
    .csr_tx_desc_is_wr_i   (csr_tx_desc_is_wr_i),
    .tx_desc_queue_ack_i   (tx_desc_queue_ack_i),
    .tx_desc_queue_full_i  (tx_desc_queue_full_i),
    .csr_tx_desc_data_i    (csr_tx_desc_data_i),
    .csr_tx_desc_ack_o     (csr_tx_desc_ack_o),
    .tx_desc_queue_req_o   (tx_desc_queue_req_o),
    .tx_desc_queue_data_o  (tx_desc_queue_data_o)
  );

endmodule : i3c_tti

// File: verif/tb_i3c_tti.sv
//*************************************************
// Self-checking testbench for the TTI glue, run as top
//*************************************************

`timescale 1ns/1ps

module tb_i3c_tti;
  import tti_pkg::*;

  // Cycle budget per test, drives the watchdog
  localparam int unsigned ResetCycles    = 12;
  localparam int unsigned SetCycles      = 50;
  localparam int unsigned RecoveryCycles = 14;
  localparam int unsigned ClearCycles    = 16;
  localparam int unsigned ForceCycles    = 12;
  localparam int unsigned GuardCycles    = 36;
  localparam int unsigned TotalCycles    = ResetCycles + SetCycles + RecoveryCycles +
                                           ClearCycles + ForceCycles + GuardCycles;
  localparam int unsigned WatchdogNs     = TotalCycles * 2 * 8;

  logic     clk_i;
  logic     rst_ni;
  logic     rx_desc_write_i;
  logic     rx_data_write_i;
  logic     rx_desc_thld_trig_i;
  logic     rx_data_thld_trig_i;
  logic     ibi_status_we_i;
  logic     tx_pr_start_i;
  logic     tx_pr_end_i;
  logic     recovery_mode_i;
  logic     rx_desc_queue_ack_i;
  logic     rx_data_queue_ack_i;
  logic     ibi_status_rd_i;
  irq_vec_t intr_w1c_i;
  irq_vec_t intr_force_i;
  irq_vec_t intr_enable_i;
  irq_vec_t intr_status_o;
  logic     irq_o;
  logic     csr_rx_desc_req_i;
  logic     rx_desc_queue_empty_i;
  desc_t    rx_desc_queue_data_i;
  logic     csr_rx_desc_ack_o;
  logic     rx_desc_queue_req_o;
  desc_t    csr_rx_desc_data_o;
  logic     csr_tx_desc_req_i;
  logic     csr_tx_desc_is_wr_i;
  logic     tx_desc_queue_ack_i;
  logic     tx_desc_queue_full_i;
  desc_t    csr_tx_desc_data_i;
  logic     csr_tx_desc_ack_o;
  logic     tx_desc_queue_req_o;
  desc_t    tx_desc_queue_data_o;

  int unsigned err_count    = 0;
  int unsigned tests_run    = 0;
  int unsigned tests_failed = 0;
  logic [31:0] rng_state    = 32'd78798;

  irq_vec_t set_now;
  irq_vec_t clr_now;
  irq_vec_t exp_set_q;
  irq_vec_t exp_clr_q;
  irq_vec_t exp_status;

  i3c_tti dut0 (.*);

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state;
  endfunction

  task automatic flag_error(input string msg);
    err_count++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  // Strobes seen this cycle, per the source mapping
  always_comb begin
    set_now = intr_force_i;
    if (!recovery_mode_i) begin
      set_now[IRQ_RX_DESC]          = set_now[IRQ_RX_DESC] | rx_desc_write_i;
      set_now[IRQ_RX_DESC_THLD]     = set_now[IRQ_RX_DESC_THLD] |
                                      (rx_desc_write_i & rx_desc_thld_trig_i);
      set_now[IRQ_RX_DATA_THLD]     = set_now[IRQ_RX_DATA_THLD] |
                                      (rx_data_write_i & rx_data_thld_trig_i);
      set_now[IRQ_TX_DESC_COMPLETE] = set_now[IRQ_TX_DESC_COMPLETE] | tx_pr_end_i;
      set_now[IRQ_TX_DESC_START]    = set_now[IRQ_TX_DESC_START] | tx_pr_start_i;
    end
    set_now[IRQ_IBI_DONE] = set_now[IRQ_IBI_DONE] | ibi_status_we_i;
    clr_now = intr_w1c_i;
    clr_now[IRQ_RX_DESC]      = clr_now[IRQ_RX_DESC] | rx_desc_queue_ack_i;
    clr_now[IRQ_RX_DESC_THLD] = clr_now[IRQ_RX_DESC_THLD] | rx_desc_queue_ack_i;
    clr_now[IRQ_RX_DATA_THLD] = clr_now[IRQ_RX_DATA_THLD] | rx_data_queue_ack_i;
    clr_now[IRQ_IBI_DONE]     = clr_now[IRQ_IBI_DONE] | ibi_status_rd_i;
  end

  // Expected status, one edge to register and one to update
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exp_set_q  <= '0;
      exp_clr_q  <= '0;
      exp_status <= '0;
    end else begin
      exp_set_q  <= set_now;
      exp_clr_q  <= clr_now;
      exp_status <= exp_set_q | (exp_status & ~exp_clr_q);
    end
  end

  a_reset_quiet : assert property (@(posedge clk_i)
    (!rst_ni || $rose(rst_ni)) |-> (!irq_o && intr_status_o == '0))
    else flag_error("interrupt outputs not zero in or right after reset");

  a_status_model : assert property (@(posedge clk_i) intr_status_o == exp_status)
    else flag_error($sformatf("status %b, expected %b",
                              $sampled(intr_status_o), $sampled(exp_status)));

  a_irq_model : assert property (@(posedge clk_i)
    irq_o == |(exp_status & intr_enable_i))
    else flag_error("irq_o differs from OR of status and enable");

  a_rx_empty : assert property (@(posedge clk_i)
    (csr_rx_desc_req_i && rx_desc_queue_empty_i) |->
      (csr_rx_desc_ack_o && csr_rx_desc_data_o == '0 && !rx_desc_queue_req_o))
    else flag_error("empty RX read not answered locally with zero data");

  a_rx_pass : assert property (@(posedge clk_i)
    !(csr_rx_desc_req_i && rx_desc_queue_empty_i) |->
      (csr_rx_desc_ack_o == rx_desc_queue_ack_i &&
       csr_rx_desc_data_o == rx_desc_queue_data_i &&
       rx_desc_queue_req_o == csr_rx_desc_req_i))
    else flag_error("RX descriptor pass-through mismatch");

  a_tx_full : assert property (@(posedge clk_i)
    (csr_tx_desc_req_i && tx_desc_queue_full_i) |->
      (csr_tx_desc_ack_o == csr_tx_desc_is_wr_i && !tx_desc_queue_req_o &&
       tx_desc_queue_data_o == '0))
    else flag_error("full TX write not acked and dropped");

  a_tx_pass : assert property (@(posedge clk_i)
    !(csr_tx_desc_req_i && tx_desc_queue_full_i) |->
      (tx_desc_queue_req_o == (csr_tx_desc_req_i & csr_tx_desc_is_wr_i) &&
       tx_desc_queue_data_o == csr_tx_desc_data_i &&
       csr_tx_desc_ack_o == tx_desc_queue_ack_i))
    else flag_error("TX descriptor pass-through mismatch");

  // Wait for n edges, then step past the drive delay
  task automatic tick(input int unsigned n);
    repeat (n) @(posedge clk_i);
    #1;
  endtask

  task automatic clear_strobes();
    rx_desc_write_i     = 1'b0;
    rx_data_write_i     = 1'b0;
    rx_desc_thld_trig_i = 1'b0;
    rx_data_thld_trig_i = 1'b0;
    ibi_status_we_i     = 1'b0;
    tx_pr_start_i       = 1'b0;
    tx_pr_end_i         = 1'b0;
    rx_desc_queue_ack_i = 1'b0;
    rx_data_queue_ack_i = 1'b0;
    ibi_status_rd_i     = 1'b0;
    intr_w1c_i          = '0;
    intr_force_i        = '0;
  endtask

  task automatic clear_guard_inputs();
    csr_rx_desc_req_i     = 1'b0;
    rx_desc_queue_empty_i = 1'b0;
    rx_desc_queue_data_i  = '0;
    csr_tx_desc_req_i     = 1'b0;
    csr_tx_desc_is_wr_i   = 1'b0;
    tx_desc_queue_ack_i   = 1'b0;
    tx_desc_queue_full_i  = 1'b0;
    csr_tx_desc_data_i    = '0;
  endtask

  // One-cycle pulse on the input that drives a source
  task automatic pulse_source(input int unsigned src);
    case (src)
      0: rx_desc_write_i = 1'b1;
      1: begin
        rx_desc_write_i     = 1'b1;
        rx_desc_thld_trig_i = 1'b1;
      end
      2: begin
        rx_data_write_i     = 1'b1;
        rx_data_thld_trig_i = 1'b1;
      end
      3: ibi_status_we_i = 1'b1;
      4: tx_pr_end_i = 1'b1;
      default: tx_pr_start_i = 1'b1;
    endcase
    tick(1);
    clear_strobes();
  endtask

  task automatic clear_all_w1c();
    intr_w1c_i = '1;
    tick(1);
    clear_strobes();
  endtask

  task automatic end_test(input string name, input int unsigned err_before);
    tick(2);
    tests_run++;
    if (err_count != err_before) begin
      tests_failed++;
    end
    $display("%s: finished with %0d errors", name, err_count - err_before);
  endtask

  task automatic reset_sequence();
    int unsigned err_before;
    err_before = err_count;
    #1 rst_ni = 1'b0;
    repeat (10) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    end_test("reset", err_before);
  endtask

  task automatic set_mapping_test();
    int unsigned err_before;
    int unsigned src;
    err_before = err_count;
    for (int i = 0; i < 12; i++) begin
      src = (i < 6) ? i : next_rand() % 6;
      intr_enable_i = irq_vec_t'(next_rand() >> 8);
      pulse_source(src);
      tick(2);
      clear_all_w1c();
    end
    end_test("set mapping", err_before);
  endtask

  task automatic recovery_test();
    int unsigned err_before;
    err_before = err_count;
    intr_enable_i   = '1;
    recovery_mode_i = 1'b1;
    for (int unsigned s = 0; s < 6; s++) begin
      pulse_source(s);
    end
    tick(2);
    clear_all_w1c();
    recovery_mode_i = 1'b0;
    end_test("recovery suppression", err_before);
  endtask

  task automatic clear_test();
    int unsigned err_before;
    err_before = err_count;
    intr_force_i = '1;
    tick(1);
    clear_strobes();
    tick(1);
    rx_desc_queue_ack_i = 1'b1;
    tick(1);
    clear_strobes();
    ibi_status_rd_i = 1'b1;
    tick(1);
    clear_strobes();
    rx_data_queue_ack_i = 1'b1;
    tick(1);
    clear_strobes();
    intr_w1c_i = 6'b110000;
    tick(1);
    clear_strobes();
    // Set and clear in one cycle, the set must hold
    rx_desc_write_i     = 1'b1;
    rx_desc_thld_trig_i = 1'b1;
    rx_desc_queue_ack_i = 1'b1;
    ibi_status_we_i     = 1'b1;
    ibi_status_rd_i     = 1'b1;
    intr_w1c_i          = 6'b001011;
    tick(1);
    clear_strobes();
    tick(2);
    clear_all_w1c();
    end_test("clearing", err_before);
  endtask

  task automatic force_test();
    int unsigned err_before;
    err_before = err_count;
    recovery_mode_i = 1'b1;
    intr_force_i    = irq_vec_t'(next_rand() >> 12);
    tick(1);
    clear_strobes();
    tick(1);
    clear_all_w1c();
    recovery_mode_i = 1'b0;
    intr_force_i    = irq_vec_t'(next_rand() >> 12);
    tick(1);
    clear_strobes();
    tick(1);
    clear_all_w1c();
    end_test("force", err_before);
  endtask

  // Walks every req, empty, full and write combination
  task automatic desc_guard_test();
    int unsigned err_before;
    logic [31:0] r;
    err_before = err_count;
    for (int unsigned i = 0; i < 32; i++) begin
      r = next_rand();
      csr_rx_desc_req_i     = i[0];
      rx_desc_queue_empty_i = i[1];
      csr_tx_desc_req_i     = i[2];
      tx_desc_queue_full_i  = i[3];
      csr_tx_desc_is_wr_i   = i[4];
      rx_desc_queue_ack_i   = r[20];
      tx_desc_queue_ack_i   = r[23];
      rx_desc_queue_data_i  = next_rand();
      csr_tx_desc_data_i    = next_rand();
      tick(1);
    end
    clear_guard_inputs();
    clear_strobes();
    end_test("descriptor guard", err_before);
  endtask

  initial begin
    clk_i           = 1'b0;
    rst_ni          = 1'b1;
    recovery_mode_i = 1'b0;
    intr_enable_i   = '0;
    clear_strobes();
    clear_guard_inputs();
    reset_sequence();
    set_mapping_test();
    recovery_test();
    clear_test();
    force_test();
    desc_guard_test();
    $display("Tests run: %0d, tests failed: %0d, errors: %0d",
             tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    #(WatchdogNs);
    $display("Timeout: the tests did not finish within %0d ns", WatchdogNs);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule : tb_i3c_tti

// File: i3c_tti.f
source/tti_pkg.sv
source/tti_event_if.sv
source/tti_event_capture.sv
source/tti_irq_status.sv
source/tti_desc_port.sv
source/i3c_tti.sv
verif/tb_i3c_tti.sv
